//--- source/tcp_rx_pkg.sv
`default_nettype none

package tcp_rx_pkg;

  // Widths that carry a meaning on the receive path
  typedef logic [15:0] port_t;
  typedef logic [31:0] tcp_num_t;
  typedef logic [15:0] pld_len_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] credit_t;

  // One segment's metadata, valid for a single cycle ahead of its bytes
  typedef struct packed {
    logic     val;
    port_t    src_port;
    port_t    dst_port;
    tcp_num_t seq_num;
    logic     ack_flag;
    pld_len_t pld_len;
  } tcp_meta_t;

  // Network byte stream, eof marks the last byte of a segment
  typedef struct packed {
    logic  val;
    byte_t dat;
    logic  err;
    logic  eof;
  } rx_strm_t;

  // Payload stream handed to the user
  typedef struct packed {
    logic  val;
    byte_t dat;
    logic  err;
    logic  eof;
  } user_strm_t;

  // Connection block negotiated during the handshake
  typedef struct packed {
    port_t    loc_port;
    port_t    rem_port;
    tcp_num_t rem_isn;
  } tcb_t;

  // Idle values for the buses
  localparam tcp_meta_t  META_IDLE      = '0;
  localparam rx_strm_t   RX_STRM_IDLE   = '0;
  localparam user_strm_t USER_STRM_IDLE = '0;

  // Default tuning of the receive engine
  localparam int DEF_ACK_TIMEOUT       = 20;
  localparam int DEF_FORCE_ACK_PACKETS = 5;
  localparam int DEF_RX_BUF_BYTES      = 1024;

endpackage : tcp_rx_pkg

`default_nettype wire

//--- source/tcp_rx_ack.sv
`default_nettype none

module tcp_rx_ack
  import tcp_rx_pkg::*;
#(
  parameter int ACK_TIMEOUT       = DEF_ACK_TIMEOUT,
  parameter int FORCE_ACK_PACKETS = DEF_FORCE_ACK_PACKETS
)
(
  input  logic     clk,
  input  logic     rst,
  input  logic     init,
  input  tcb_t     tcb,
  input  logic     accept,
  input  pld_len_t acc_len,
  input  logic     out_of_order,
  input  logic     ack_sent,
  output tcp_num_t loc_ack,
  output logic     send_ack
);

  localparam int CNT_W = $clog2(FORCE_ACK_PACKETS + 1);
  localparam int TMR_W = $clog2(ACK_TIMEOUT + 1);

  logic [CNT_W-1:0] pending;
  logic [TMR_W-1:0] timer;
  logic             pending_nz;
  logic             force_hit;
  logic             timeout_hit;

  // Local acknowledgement number, loaded from the handshake result
  always_ff @(posedge clk) begin
    if (rst) begin
      loc_ack <= '0;
    end else if (init) begin
      loc_ack <= tcb.rem_isn;
    end else if (accept) begin
      // Wraps modulo 2^32 like any TCP sequence space
      loc_ack <= loc_ack + tcp_num_t'(acc_len);
    end
  end

  assign pending_nz  = (pending != '0);
  assign force_hit   = accept && (pending == CNT_W'(FORCE_ACK_PACKETS - 1));
  assign timeout_hit = pending_nz && (timer == TMR_W'(ACK_TIMEOUT - 1));

  // Pending segment count, timeout timer and the request level
  always_ff @(posedge clk) begin
    if (rst) begin
      pending  <= '0;
      timer    <= '0;
      send_ack <= 1'b0;
    end else if (ack_sent) begin
      // A segment accepted alongside the ACK still needs its own
      pending  <= accept ? CNT_W'(1) : '0;
      timer    <= accept ? TMR_W'(1) : '0;
      send_ack <= out_of_order;
    end else begin
      if (accept && pending != CNT_W'(FORCE_ACK_PACKETS)) begin
        pending <= pending + 1'b1;
      end
      // The timer starts on the first pending accept and holds at the limit
      if ((accept || pending_nz) && !timeout_hit) begin
        timer <= timer + 1'b1;
      end
      if (force_hit || timeout_hit || out_of_order) begin
        send_ack <= 1'b1;
      end
    end
  end

  // The transmitter only reports an ACK that was requested
  assert property (@(posedge clk) disable iff (rst) ack_sent |-> send_ack)
    else $error("ack_sent seen without a pending send_ack");

  // Connection setup and segment acceptance are never concurrent
  assert property (@(posedge clk) disable iff (rst) !(accept && init))
    else $error("segment accepted during init");

endmodule : tcp_rx_ack

`default_nettype wire

//--- source/tcp_rx_credit.sv
`default_nettype none

module tcp_rx_credit
  import tcp_rx_pkg::*;
#(
  parameter int RX_BUF_BYTES = DEF_RX_BUF_BYTES
)
(
  input  logic     clk,
  input  logic     rst,
  input  logic     take_val,
  input  pld_len_t take_len,
  input  logic     credit_ret,
  output credit_t  avail
);

  credit_t take_amt;
  credit_t ret_amt;

  assign take_amt = take_val ? credit_t'(take_len) : '0;
  assign ret_amt  = credit_t'(credit_ret);

  // Free bytes in the user buffer, a take and a return may land together
  always_ff @(posedge clk) begin
    if (rst) begin
      avail <= credit_t'(RX_BUF_BYTES);
    end else begin
      avail <= avail - take_amt + ret_amt;
    end
  end

  // The user never frees more than was handed over
  assert property (@(posedge clk) disable iff (rst) avail <= credit_t'(RX_BUF_BYTES))
    else $error("credit pool above buffer size");

  // The controller checks credits before it takes any
  assert property (@(posedge clk) disable iff (rst)
    take_val |-> (credit_t'(take_len) <= avail))
    else $error("credit take larger than available");

endmodule : tcp_rx_credit

`default_nettype wire

//--- source/tcp_rx_ctl.sv
`default_nettype none

module tcp_rx_ctl
  import tcp_rx_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  tcp_meta_t  meta,
  input  rx_strm_t   strm,
  input  tcb_t       tcb,
  input  logic       connected,
  input  tcp_num_t   loc_ack,
  input  credit_t    avail,
  output logic       accept,
  output pld_len_t   acc_len,
  output logic       out_of_order,
  output logic       take_val,
  output pld_len_t   take_len,
  output user_strm_t data
);

  logic     port_match;
  logic     live;
  logic     in_order;
  logic     fits;
  logic     receiving;
  rx_strm_t strm_r;

  // Segment belongs to this connection and carries payload
  assign port_match = meta.val &&
                      (meta.src_port == tcb.rem_port) &&
                      (meta.dst_port == tcb.loc_port);
  assign live       = port_match && connected && (meta.pld_len != '0);
  assign in_order   = (meta.seq_num == loc_ack);
  assign fits       = (credit_t'(meta.pld_len) <= avail);

  // Decision is taken in the meta cycle itself
  assign accept       = live && meta.ack_flag && in_order && fits;
  assign out_of_order = live && !in_order;

  assign acc_len  = meta.pld_len;
  assign take_val = accept;
  assign take_len = meta.pld_len;

  // Stream is registered once, then forwarded while a segment is accepted
  always_ff @(posedge clk) begin
    if (rst) begin
      strm_r    <= RX_STRM_IDLE;
      data      <= USER_STRM_IDLE;
      receiving <= 1'b0;
    end else begin
      strm_r <= strm;
      if (receiving) begin
        data.val <= strm_r.val;
        data.dat <= strm_r.dat;
        data.err <= strm_r.err;
        data.eof <= strm_r.eof;
      end else begin
        data <= USER_STRM_IDLE;
      end
      // A new accept wins over the end of the previous segment
      if (accept) begin
        receiving <= 1'b1;
      end else if (strm_r.val && strm_r.eof) begin
        receiving <= 1'b0;
      end
    end
  end

endmodule : tcp_rx_ctl

`default_nettype wire

//--- source/tcp_rx_top.sv
`default_nettype none

module tcp_rx_top
  import tcp_rx_pkg::*;
#(
  parameter int ACK_TIMEOUT       = DEF_ACK_TIMEOUT,
  parameter int FORCE_ACK_PACKETS = DEF_FORCE_ACK_PACKETS,
  parameter int RX_BUF_BYTES      = DEF_RX_BUF_BYTES
)
(
  input  logic       clk,
  input  logic       rst,
  input  tcp_meta_t  meta,
  input  rx_strm_t   strm,
  input  tcb_t       tcb,
  input  logic       init,
  input  logic       connected,
  input  logic       ack_sent,
  input  logic       credit_ret,
  output user_strm_t data,
  output tcp_num_t   loc_ack,
  output logic       send_ack
);

  logic     accept;
  pld_len_t acc_len;
  logic     out_of_order;
  logic     take_val;
  pld_len_t take_len;
  credit_t  avail;

  // Segment filter, in-order check and payload gating
  tcp_rx_ctl i_tcp_rx_ctl (
    .clk          (clk),
    .rst          (rst),
    .meta         (meta),
    .strm         (strm),
    .tcb          (tcb),
    .connected    (connected),
    .loc_ack      (loc_ack),
    .avail        (avail),
    .accept       (accept),
    .acc_len      (acc_len),
    .out_of_order (out_of_order),
    .take_val     (take_val),
    .take_len     (take_len),
    .data         (data)
  );

  // Acknowledgement number and ACK request toward the transmitter
  tcp_rx_ack #(
    .ACK_TIMEOUT       (ACK_TIMEOUT),
    .FORCE_ACK_PACKETS (FORCE_ACK_PACKETS)
  ) i_tcp_rx_ack (
    .clk          (clk),
    .rst          (rst),
    .init         (init),
    .tcb          (tcb),
    .accept       (accept),
    .acc_len      (acc_len),
    .out_of_order (out_of_order),
    .ack_sent     (ack_sent),
    .loc_ack      (loc_ack),
    .send_ack     (send_ack)
  );

  // Free space of the user receive buffer
  tcp_rx_credit #(
    .RX_BUF_BYTES (RX_BUF_BYTES)
  ) i_tcp_rx_credit (
    .clk        (clk),
    .rst        (rst),
    .take_val   (take_val),
    .take_len   (take_len),
    .credit_ret (credit_ret),
    .avail      (avail)
  );

endmodule : tcp_rx_top

`default_nettype wire

//--- sim/tcp_rx_tb.sv
`default_nettype none

module tcp_rx_tb
  import tcp_rx_pkg::*;
();

  localparam int ACK_TIMEOUT       = 40;
  localparam int FORCE_ACK_PACKETS = 3;
  localparam int RX_BUF_BYTES      = 64;
  localparam int NUM_ROWS          = 14;

  localparam port_t    LOC_PORT = 16'h1f90;
  localparam port_t    REM_PORT = 16'hc350;
  // Close to the top of the sequence space so loc_ack wraps during the run
  localparam tcp_num_t REM_ISN  = 32'hffff_ffd0;

  // One table row describes a segment whose sequence number lies seq_off past the expected ACK
  typedef struct packed {
    port_t      src;
    port_t      dst;
    tcp_num_t   seq_off;
    logic       ack;
    pld_len_t   len;
    credit_t    ret;
    logic       conn;
    logic [7:0] idle;
  } seg_row_t;

  logic       clk;
  logic       rst;
  tcp_meta_t  meta;
  rx_strm_t   strm;
  tcb_t       tcb;
  logic       init;
  logic       connected;
  logic       ack_sent;
  logic       credit_ret;
  user_strm_t data;
  tcp_num_t   loc_ack;
  logic       send_ack;

  seg_row_t    rows [NUM_ROWS];
  user_strm_t  exp_q [$];
  logic [31:0] lfsr = 32'h34bd584b;
  tcp_num_t    exp_ack;
  int          credits = 0;
  int          pending = 0;
  int          first_cyc = 0;
  int          cyc = 0;
  logic        req_exp = 1'b0;
  logic        cur_acc = 1'b0;
  logic        cur_ooo = 1'b0;
  int          checks = 0;
  int          mismatches = 0;
  int          other_errs = 0;
  int          run_limit = 0;
  int          wd_cyc = 0;

  tcp_rx_top #(
    .ACK_TIMEOUT       (ACK_TIMEOUT),
    .FORCE_ACK_PACKETS (FORCE_ACK_PACKETS),
    .RX_BUF_BYTES      (RX_BUF_BYTES)
  ) i_tcp_rx_top (
    .clk        (clk),
    .rst        (rst),
    .meta       (meta),
    .strm       (strm),
    .tcb        (tcb),
    .init       (init),
    .connected  (connected),
    .ack_sent   (ack_sent),
    .credit_ret (credit_ret),
    .data       (data),
    .loc_ack    (loc_ack),
    .send_ack   (send_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic byte_t next_byte();
    byte_t b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  task automatic check_byte(input user_strm_t got, input user_strm_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: data (val dat err eof) got %b %h %b %b, expected %b %h %b %b",
               $time, got.val, got.dat, got.err, got.eof, exp.val, exp.dat, exp.err, exp.eof);
    end
  endtask

  task automatic check_ack(input tcp_num_t got, input tcp_num_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: loc_ack got %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_req(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: send_ack got %b, expected %b", $time, got, exp);
    end
  endtask

  // Advance one cycle, predicting send_ack from the inputs of the cycle that ends
  task automatic tick();
    if (ack_sent) begin
      pending = cur_acc ? 1 : 0;
      req_exp = cur_ooo;
      if (cur_acc) begin
        first_cyc = cyc;
      end
    end else begin
      if (cur_acc) begin
        if (pending == 0) begin
          first_cyc = cyc;
        end
        if (pending < FORCE_ACK_PACKETS) begin
          pending++;
        end
        if (pending == FORCE_ACK_PACKETS) begin
          req_exp = 1'b1;
        end
      end
      if (cur_ooo) begin
        req_exp = 1'b1;
      end
    end
    @(posedge clk);
    #10;
    cyc++;
    // Timeout counts from the meta cycle of the first unacknowledged segment
    if (pending != 0 && cyc == first_cyc + ACK_TIMEOUT) begin
      req_exp = 1'b1;
    end
    check_req(send_ack, req_exp);
    meta       = META_IDLE;
    strm       = RX_STRM_IDLE;
    init       = 1'b0;
    credit_ret = 1'b0;
    cur_acc    = 1'b0;
    cur_ooo    = 1'b0;
    // The transmitter answers a request as soon as it sees it
    ack_sent   = req_exp && send_ack;
  endtask

  task automatic run_row(input seg_row_t r);
    int       n;
    tcp_num_t seq;
    logic     match;
    logic     acc;
    byte_t    b;
    logic     eof;
    n = int'(r.ret);
    // Only bytes that the user actually holds can be freed
    if (n > RX_BUF_BYTES - credits) begin
      n = RX_BUF_BYTES - credits;
    end
    repeat (n) begin
      credit_ret = 1'b1;
      credits++;
      tick();
    end
    connected = r.conn;
    seq   = exp_ack + r.seq_off;
    match = (r.src == REM_PORT) && (r.dst == LOC_PORT) && r.conn && (r.len != '0);
    acc   = match && r.ack && (seq == exp_ack) && (int'(r.len) <= credits);
    cur_acc = acc;
    cur_ooo = match && (seq != exp_ack);
    meta = '{1'b1, r.src, r.dst, seq, r.ack, r.len};
    if (acc) begin
      exp_ack = exp_ack + tcp_num_t'(r.len);
      credits = credits - int'(r.len);
    end
    tick();
    for (int i = 0; i < int'(r.len); i++) begin
      b    = next_byte();
      eof  = (i == int'(r.len) - 1);
      strm = '{1'b1, b, 1'b0, eof};
      if (acc) begin
        exp_q.push_back(user_strm_t'{1'b1, b, 1'b0, eof});
      end
      tick();
    end
    repeat (3) tick();
    check_ack(loc_ack, exp_ack);
    repeat (int'(r.idle)) tick();
    connected = 1'b1;
  endtask

  task automatic load_table();
    rows[0]  = '{REM_PORT, LOC_PORT, 32'd0,   1'b1, 16'd12, 16'd0,  1'b1, 8'd0};
    rows[1]  = '{REM_PORT, LOC_PORT, 32'd0,   1'b1, 16'd10, 16'd0,  1'b1, 8'd0};
    rows[2]  = '{REM_PORT, LOC_PORT, 32'd0,   1'b1, 16'd8,  16'd0,  1'b1, 8'd0};
    rows[3]  = '{16'h0050, LOC_PORT, 32'd0,   1'b1, 16'd6,  16'd0,  1'b1, 8'd0};
    rows[4]  = '{REM_PORT, 16'h0051, 32'd0,   1'b1, 16'd5,  16'd0,  1'b1, 8'd0};
    rows[5]  = '{REM_PORT, LOC_PORT, 32'd0,   1'b0, 16'd7,  16'd0,  1'b1, 8'd0};
    rows[6]  = '{REM_PORT, LOC_PORT, 32'd0,   1'b1, 16'd0,  16'd0,  1'b1, 8'd0};
    rows[7]  = '{REM_PORT, LOC_PORT, 32'd100, 1'b1, 16'd6,  16'd0,  1'b1, 8'd0};
    rows[8]  = '{REM_PORT, LOC_PORT, 32'd0,   1'b1, 16'd9,  16'd10, 1'b1, 8'd45};
    rows[9]  = '{REM_PORT, LOC_PORT, 32'd0,   1'b1, 16'd24, 16'd0,  1'b1, 8'd0};
    rows[10] = '{REM_PORT, LOC_PORT, 32'd0,   1'b1, 16'd16, 16'd0,  1'b1, 8'd0};
    rows[11] = '{REM_PORT, LOC_PORT, 32'd0,   1'b1, 16'd16, 16'd8,  1'b1, 8'd0};
    rows[12] = '{REM_PORT, LOC_PORT, 32'd0,   1'b1, 16'd3,  16'd0,  1'b0, 8'd0};
    rows[13] = '{REM_PORT, LOC_PORT, 32'd0,   1'b1, 16'd3,  16'd20, 1'b1, 8'd0};
  endtask

  // Every user beat must match the oldest byte still owed
  always @(negedge clk) begin
    if (!rst && data.val) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("Data byte %h reached the user at %0t with no accepted segment",
                 data.dat, $time);
      end else begin
        check_byte(data, exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    wd_cyc = wd_cyc + 1;
    if (wd_cyc >= run_limit) begin
      $display("Timeout: run did not finish within %0d cycles", run_limit);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    rst        = 1'b1;
    meta       = META_IDLE;
    strm       = RX_STRM_IDLE;
    tcb        = '{LOC_PORT, REM_PORT, REM_ISN};
    init       = 1'b0;
    connected  = 1'b0;
    ack_sent   = 1'b0;
    credit_ret = 1'b0;
    load_table();
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_limit += int'(rows[i].len) + 60;
    end
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;
    check_ack(loc_ack, '0);
    check_req(send_ack, 1'b0);
    credits   = RX_BUF_BYTES;
    // Connection comes up with the negotiated initial sequence number
    init      = 1'b1;
    connected = 1'b1;
    exp_ack   = REM_ISN;
    tick();
    check_ack(loc_ack, exp_ack);
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end
    // Let a last pending segment time out and be acknowledged
    repeat (ACK_TIMEOUT + 5) tick();
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("%0d accepted payload bytes never reached the user", exp_q.size());
    end
    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             checks, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tcp_rx_tb

`default_nettype wire

//--- verilog.f
source/tcp_rx_pkg.sv
source/tcp_rx_ack.sv
source/tcp_rx_credit.sv
source/tcp_rx_ctl.sv
source/tcp_rx_top.sv
sim/tcp_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the receive engine with its testbench and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tcp_rx_tb -o tcp_rx_sim \
  && out=$(./obj_dir/tcp_rx_sim) \
  || { echo "$out"; echo "Build or simulation run failed"; exit 1; }
echo "$out"
echo "$out" | grep -q "All tests passed!" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
